//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_dma_test_node
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
dma_node_pkg.sv
dma_copy_engine.sv
dma_addr_router.sv
dma_local_mem.sv
dma_test_node.sv
tb_dma_test_node.sv

//--- dma_addr_router.sv
/*
 * DMA address router
 * steers each engine access to the local memory or the external
 * port and muxes the reply back, one access in flight
 */

`timescale 1ns/1ps
`default_nettype none

module dma_addr_router #(
  parameter dma_node_pkg::addr_t MemBaseAddr = '0,
  parameter int                  MemWords    = 1024
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  bus_req_valid_i,
  input  wire logic                  bus_req_we_i,
  output logic                       bus_req_ready_o,
  input  wire dma_node_pkg::addr_t   bus_req_addr_i,
  input  wire dma_node_pkg::data_t   bus_req_wdata_i,
  output logic                       bus_rep_valid_o,
  output logic                       bus_rep_err_o,
  output dma_node_pkg::data_t        bus_rep_rdata_o,
  output logic                       mem_req_valid_o,
  output logic                       mem_req_we_o,
  output dma_node_pkg::addr_t        mem_req_addr_o,
  output dma_node_pkg::data_t        mem_req_wdata_o,
  input  wire logic                  mem_rep_valid_i,
  input  wire dma_node_pkg::data_t   mem_rep_rdata_i,
  output logic                       ext_req_valid_o,
  output logic                       ext_req_we_o,
  input  wire logic                  ext_req_ready_i,
  output dma_node_pkg::addr_t        ext_req_addr_o,
  output dma_node_pkg::data_t        ext_req_wdata_o,
  input  wire logic                  ext_rep_valid_i,
  input  wire dma_node_pkg::data_t   ext_rep_rdata_i,
  input  wire logic                  ext_rep_err_i
);

  import dma_node_pkg::*;

  localparam addr_t MemEndAddr = MemBaseAddr + addr_t'(MemWords * 4);

  logic sel_local;
  logic busy_q;
  // 1 when the local memory owns the access in flight
  logic owner_q;

  // ----------------------------
  // request side
  // ----------------------------
  assign sel_local = (bus_req_addr_i >= MemBaseAddr) && (bus_req_addr_i < MemEndAddr);

  assign mem_req_valid_o = bus_req_valid_i && !busy_q && sel_local;
  assign ext_req_valid_o = bus_req_valid_i && !busy_q && !sel_local;
  // memory side never stalls
  assign bus_req_ready_o = !busy_q && (sel_local || ext_req_ready_i);

  assign mem_req_we_o    = bus_req_we_i;
  assign mem_req_addr_o  = bus_req_addr_i;
  assign mem_req_wdata_o = bus_req_wdata_i;
  assign ext_req_we_o    = bus_req_we_i;
  assign ext_req_addr_o  = bus_req_addr_i;
  assign ext_req_wdata_o = bus_req_wdata_i;

  // ----------------------------
  // reply side
  // ----------------------------
  assign bus_rep_valid_o = busy_q && (owner_q ? mem_rep_valid_i : ext_rep_valid_i);
  assign bus_rep_rdata_o = owner_q ? mem_rep_rdata_i : ext_rep_rdata_i;
  assign bus_rep_err_o   = owner_q ? 1'b0 : ext_rep_err_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end else if (bus_req_valid_i && bus_req_ready_o) begin
      busy_q  <= 1'b1;
      owner_q <= sel_local;
    end else if (bus_rep_valid_o) begin
      busy_q  <= 1'b0;
    end
  end

  // replies only for an access that was sent out
  assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_rep_valid_i || ext_rep_valid_i) |-> busy_q);

endmodule

`default_nettype wire

//--- dma_copy_engine.sv
/*
 * DMA word copy engine
 * takes one job at a time and copies it word by word,
 * a read then a write per word, then reports a status
 */

`timescale 1ns/1ps
`default_nettype none

module dma_copy_engine (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  job_valid_i,
  output logic                       job_ready_o,
  input  wire dma_node_pkg::addr_t   job_src_i,
  input  wire dma_node_pkg::addr_t   job_dst_i,
  input  wire dma_node_pkg::len_t    job_len_i,
  output logic                       rsp_valid_o,
  input  wire logic                  rsp_ready_i,
  output dma_node_pkg::status_e      rsp_status_o,
  output logic                       bus_req_valid_o,
  output logic                       bus_req_we_o,
  input  wire logic                  bus_req_ready_i,
  output dma_node_pkg::addr_t        bus_req_addr_o,
  output dma_node_pkg::data_t        bus_req_wdata_o,
  input  wire logic                  bus_rep_valid_i,
  input  wire logic                  bus_rep_err_i,
  input  wire dma_node_pkg::data_t   bus_rep_rdata_i
);

  import dma_node_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    READ_WAIT,
    WRITE,
    WRITE_WAIT,
    RESP
  } state_e;

  state_e  state_q, state_d;
  logic    job_ready_q;
  addr_t   src_q;
  addr_t   dst_q;
  len_t    count_q;
  data_t   buf_q;
  status_e status_q;

  // ----------------------------
  // next state
  // ----------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (job_valid_i && job_ready_q) begin
          state_d = (job_len_i == '0) ? RESP : READ;
        end
      end
      READ:  if (bus_req_ready_i) state_d = READ_WAIT;
      READ_WAIT: begin
        if (bus_rep_valid_i) state_d = bus_rep_err_i ? RESP : WRITE;
      end
      WRITE: if (bus_req_ready_i) state_d = WRITE_WAIT;
      WRITE_WAIT: begin
        if (bus_rep_valid_i) begin
          // last word or error ends the job
          if (bus_rep_err_i || count_q == len_t'(1)) state_d = RESP;
          else state_d = READ;
        end
      end
      RESP:  if (rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      job_ready_q <= 1'b0;
      status_q    <= STATUS_OK;
    end else begin
      state_q     <= state_d;
      // ready only once idle has been reached, low for a cycle after reset
      job_ready_q <= (state_d == IDLE);
      if (state_q == IDLE && job_valid_i && job_ready_q) begin
        status_q <= (job_len_i == '0) ? STATUS_ZERO_LEN : STATUS_OK;
      end else if ((state_q == READ_WAIT || state_q == WRITE_WAIT) &&
                   bus_rep_valid_i && bus_rep_err_i) begin
        status_q <= STATUS_BUS_ERR;
      end
    end
  end

  // address, count and word buffer
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && job_valid_i && job_ready_q) begin
      src_q   <= job_src_i;
      dst_q   <= job_dst_i;
      count_q <= job_len_i;
    end else if (state_q == WRITE_WAIT && bus_rep_valid_i) begin
      src_q   <= src_q + addr_t'(4);
      dst_q   <= dst_q + addr_t'(4);
      count_q <= count_q - len_t'(1);
    end
    if (state_q == READ_WAIT && bus_rep_valid_i) begin
      buf_q <= bus_rep_rdata_i;
    end
  end

  // ----------------------------
  // outputs
  // ----------------------------
  assign job_ready_o     = job_ready_q;
  assign rsp_valid_o     = (state_q == RESP);
  assign rsp_status_o    = status_q;
  assign bus_req_valid_o = (state_q == READ) || (state_q == WRITE);
  assign bus_req_we_o    = (state_q == WRITE);
  assign bus_req_addr_o  = (state_q == WRITE) ? dst_q : src_q;
  assign bus_req_wdata_o = buf_q;

  // request held until the router takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o &&
      $stable(bus_req_we_o) && $stable(bus_req_addr_o) && $stable(bus_req_wdata_o));

  // an error reply ends the job with an error status
  assert property (@(posedge clk_i) disable iff (reset_i)
    bus_rep_valid_i && bus_rep_err_i |=> rsp_valid_o && rsp_status_o != STATUS_OK);

endmodule

`default_nettype wire

//--- dma_local_mem.sv
/*
 * DMA node local memory
 * word array at MemBaseAddr, always ready, reply one cycle later
 */

`timescale 1ns/1ps
`default_nettype none

module dma_local_mem #(
  parameter dma_node_pkg::addr_t MemBaseAddr = '0,
  parameter int                  MemWords    = 1024
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  mem_req_valid_i,
  input  wire logic                  mem_req_we_i,
  input  wire dma_node_pkg::addr_t   mem_req_addr_i,
  input  wire dma_node_pkg::data_t   mem_req_wdata_i,
  output logic                       mem_rep_valid_o,
  output dma_node_pkg::data_t        mem_rep_rdata_o
);

  import dma_node_pkg::*;

  localparam int IdxWidth = $clog2(MemWords);

  data_t                mem [MemWords];
  data_t                rdata_q;
  logic                 rep_valid_q;
  addr_t                offset;
  logic [IdxWidth-1:0]  idx;

  // byte offset into the array, low two bits select a byte
  assign offset = mem_req_addr_i - MemBaseAddr;
  assign idx    = offset[IdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (mem_req_valid_i) begin
      if (mem_req_we_i) mem[idx] <= mem_req_wdata_i;
      else rdata_q <= mem[idx];
    end
  end

  // every request gets a reply, writes too
  always_ff @(posedge clk_i) begin
    if (reset_i) rep_valid_q <= 1'b0;
    else rep_valid_q <= mem_req_valid_i;
  end

  assign mem_rep_valid_o = rep_valid_q;
  assign mem_rep_rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- dma_node_pkg.sv
/*
 * DMA test node shared definitions
 * bus widths, word and address types, job status codes
 */

`default_nettype none

package dma_node_pkg;

  // ----------------------------
  // widths
  // ----------------------------
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int LenWidth  = 16;

  // byte address on the node bus
  typedef logic [AddrWidth-1:0] addr_t;

  // one memory word
  typedef logic [DataWidth-1:0] data_t;

  // job length in words
  typedef logic [LenWidth-1:0] len_t;

  // ----------------------------
  // job result
  // ----------------------------
  typedef enum logic [1:0] {
    STATUS_OK       = 2'd0,
    STATUS_ZERO_LEN = 2'd1,
    STATUS_BUS_ERR  = 2'd2
  } status_e;

endpackage

`default_nettype wire

//--- dma_test_node.sv
/*
 * DMA test node top
 * copy engine, address router and local memory,
 * with an external port for everything outside the local range
 */

`timescale 1ns/1ps
`default_nettype none

module dma_test_node #(
  parameter dma_node_pkg::addr_t MemBaseAddr = '0,
  parameter int                  MemWords    = 1024
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  job_valid_i,
  output logic                       job_ready_o,
  input  wire dma_node_pkg::addr_t   job_src_i,
  input  wire dma_node_pkg::addr_t   job_dst_i,
  input  wire dma_node_pkg::len_t    job_len_i,
  output logic                       rsp_valid_o,
  input  wire logic                  rsp_ready_i,
  output dma_node_pkg::status_e      rsp_status_o,
  output logic                       ext_req_valid_o,
  input  wire logic                  ext_req_ready_i,
  output logic                       ext_req_we_o,
  output dma_node_pkg::addr_t        ext_req_addr_o,
  output dma_node_pkg::data_t        ext_req_wdata_o,
  input  wire logic                  ext_rep_valid_i,
  input  wire dma_node_pkg::data_t   ext_rep_rdata_i,
  input  wire logic                  ext_rep_err_i
);

  import dma_node_pkg::*;

  // ----------------------------
  // engine to router
  // ----------------------------
  logic  req_valid;
  logic  req_ready;
  logic  req_we;
  addr_t req_addr;
  data_t req_wdata;
  logic  rep_valid;
  data_t rep_rdata;
  logic  rep_err;

  // router to local memory
  logic  mem_req_valid;
  logic  mem_req_we;
  addr_t mem_req_addr;
  data_t mem_req_wdata;
  logic  mem_rep_valid;
  data_t mem_rep_rdata;

  dma_copy_engine i_engine (
    .clk_i           ( clk_i        ),
    .reset_i         ( reset_i      ),
    .job_valid_i     ( job_valid_i  ),
    .job_ready_o     ( job_ready_o  ),
    .job_src_i       ( job_src_i    ),
    .job_dst_i       ( job_dst_i    ),
    .job_len_i       ( job_len_i    ),
    .rsp_valid_o     ( rsp_valid_o  ),
    .rsp_ready_i     ( rsp_ready_i  ),
    .rsp_status_o    ( rsp_status_o ),
    .bus_req_valid_o ( req_valid    ),
    .bus_req_we_o    ( req_we       ),
    .bus_req_ready_i ( req_ready    ),
    .bus_req_addr_o  ( req_addr     ),
    .bus_req_wdata_o ( req_wdata    ),
    .bus_rep_valid_i ( rep_valid    ),
    .bus_rep_err_i   ( rep_err      ),
    .bus_rep_rdata_i ( rep_rdata    )
  );

  dma_addr_router #(
    .MemBaseAddr ( MemBaseAddr ),
    .MemWords    ( MemWords    )
  ) i_router (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .bus_req_valid_i ( req_valid       ),
    .bus_req_we_i    ( req_we          ),
    .bus_req_ready_o ( req_ready       ),
    .bus_req_addr_i  ( req_addr        ),
    .bus_req_wdata_i ( req_wdata       ),
    .bus_rep_valid_o ( rep_valid       ),
    .bus_rep_err_o   ( rep_err         ),
    .bus_rep_rdata_o ( rep_rdata       ),
    .mem_req_valid_o ( mem_req_valid   ),
    .mem_req_we_o    ( mem_req_we      ),
    .mem_req_addr_o  ( mem_req_addr    ),
    .mem_req_wdata_o ( mem_req_wdata   ),
    .mem_rep_valid_i ( mem_rep_valid   ),
    .mem_rep_rdata_i ( mem_rep_rdata   ),
    .ext_req_valid_o ( ext_req_valid_o ),
    .ext_req_we_o    ( ext_req_we_o    ),
    .ext_req_ready_i ( ext_req_ready_i ),
    .ext_req_addr_o  ( ext_req_addr_o  ),
    .ext_req_wdata_o ( ext_req_wdata_o ),
    .ext_rep_valid_i ( ext_rep_valid_i ),
    .ext_rep_rdata_i ( ext_rep_rdata_i ),
    .ext_rep_err_i   ( ext_rep_err_i   )
  );

  dma_local_mem #(
    .MemBaseAddr ( MemBaseAddr ),
    .MemWords    ( MemWords    )
  ) i_local_mem (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .mem_req_valid_i ( mem_req_valid ),
    .mem_req_we_i    ( mem_req_we    ),
    .mem_req_addr_i  ( mem_req_addr  ),
    .mem_req_wdata_i ( mem_req_wdata ),
    .mem_rep_valid_o ( mem_rep_valid ),
    .mem_rep_rdata_o ( mem_rep_rdata )
  );

endmodule

`default_nettype wire

//--- dma_vectors.txt
// words 00-0f: external memory image from byte address 10000000
// word 10: external address that replies with an error, word 11: job count
// from word 12, one job per line: source, destination, length, expected status
@00
1234abcd 0badf00d cafe0001 5eed0094
a5a5a5a5 5a5a5a5a 00000000 ffffffff
13579bdf 2468ace0 deadbeef 0f0f0f0f
87654321 11112222 33334444 55556666
@10
10000018
00000006
// external to local, then local to external
10000000 00000100 00000004 00000000
00000100 10000080 00000004 00000000
// local to local, checked by copying it out again
00000100 00000200 00000004 00000000
00000200 100000c0 00000004 00000000
// zero length
10000000 10000040 00000000 00000001
// third read hits the error address
10000010 00000300 00000004 00000002

//--- tb_dma_test_node.sv
/*
 * DMA test node testbench
 * external memory model with random reply delay, job driver
 * from the vectors file, and checks on the external bus and responses
 */

`timescale 1ns/1ps
`default_nettype none

module tb_dma_test_node;

  import dma_node_pkg::*;

  localparam addr_t LocalBase     = 32'h0000_0000;
  localparam int    LocalWords    = 1024;
  localparam addr_t ExtBase       = 32'h1000_0000;
  localparam int    ExtWords      = 64;
  localparam int    ImageWords    = 16;
  localparam int    VecWords      = 64;
  localparam int    ErrAddrIdx    = 16;
  localparam int    JobCountIdx   = 17;
  localparam int    JobBaseIdx    = 18;
  localparam int    ExpMax        = 64;
  localparam int    AcceptTimeout = 100;
  localparam int    RspTimeout    = 2000;

  logic    clk_i = 1'b0;
  logic    reset_i;
  logic    job_valid_i;
  logic    job_ready_o;
  addr_t   job_src_i;
  addr_t   job_dst_i;
  len_t    job_len_i;
  logic    rsp_valid_o;
  logic    rsp_ready_i;
  status_e rsp_status_o;
  logic    ext_req_valid_o;
  logic    ext_req_ready_i;
  logic    ext_req_we_o;
  addr_t   ext_req_addr_o;
  data_t   ext_req_wdata_o;
  logic    ext_rep_valid_i;
  data_t   ext_rep_rdata_i;
  logic    ext_rep_err_i;

  data_t       vec [VecWords];
  data_t       ext_mem [ExtWords];
  data_t       ref_ext [ExtWords];
  data_t       ref_local [LocalWords];
  data_t       exp_words [ExpMax];
  addr_t       err_addr;
  logic [15:0] lfsr_rsp;
  int          errors;
  int          timeouts;

  // state of the job in progress, seen by the bus watcher
  addr_t cur_src;
  addr_t cur_dst;
  len_t  cur_len;
  int    rd_idx;
  int    wr_idx;
  int    ext_count;
  logic  err_seen;

  always #5 clk_i = ~clk_i;

  dma_test_node #(
    .MemBaseAddr ( LocalBase  ),
    .MemWords    ( LocalWords )
  ) DUT (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .job_valid_i     ( job_valid_i     ),
    .job_ready_o     ( job_ready_o     ),
    .job_src_i       ( job_src_i       ),
    .job_dst_i       ( job_dst_i       ),
    .job_len_i       ( job_len_i       ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_ready_i     ( rsp_ready_i     ),
    .rsp_status_o    ( rsp_status_o    ),
    .ext_req_valid_o ( ext_req_valid_o ),
    .ext_req_ready_i ( ext_req_ready_i ),
    .ext_req_we_o    ( ext_req_we_o    ),
    .ext_req_addr_o  ( ext_req_addr_o  ),
    .ext_req_wdata_o ( ext_req_wdata_o ),
    .ext_rep_valid_i ( ext_rep_valid_i ),
    .ext_rep_rdata_i ( ext_rep_rdata_i ),
    .ext_rep_err_i   ( ext_rep_err_i   )
  );

  // ----------------------------
  // helpers
  // ----------------------------
  // 16 bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(inout logic [15:0] s, input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      s = lfsr_next(s);
      v = v * 2 + int'(s[0]);
    end
  endtask

  function automatic logic is_local(input addr_t addr);
    return addr >= LocalBase && addr < LocalBase + addr_t'(LocalWords * 4);
  endfunction

  function automatic logic is_ext(input addr_t addr);
    return addr >= ExtBase && addr < ExtBase + addr_t'(ExtWords * 4);
  endfunction

  // image words from the file, the rest a pattern of the full address
  function automatic data_t ext_init_word(input int i);
    if (i < ImageWords) return vec[i];
    return data_t'(ExtBase + addr_t'(4 * i)) ^ 32'h5a5a_0000;
  endfunction

  function automatic data_t ref_read(input addr_t addr);
    if (is_local(addr)) return ref_local[int'((addr - LocalBase) >> 2)];
    if (is_ext(addr)) return ref_ext[int'((addr - ExtBase) >> 2)];
    return 'x;
  endfunction

  task automatic ref_write(input addr_t addr, input data_t data);
    if (is_local(addr)) ref_local[int'((addr - LocalBase) >> 2)] = data;
    else if (is_ext(addr)) ref_ext[int'((addr - ExtBase) >> 2)] = data;
  endtask

  // ----------------------------
  // checks
  // ----------------------------
  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input status_e got, input status_e exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // called at each rising edge while a job runs
  task automatic watch_ext_bus();
    if (ext_req_valid_o && ext_req_ready_i) begin
      ext_count++;
      if (err_seen) begin
        errors++;
        $display("error at %0t ns: external request after a bus error reply", $time);
      end else if (ext_req_we_o) begin
        if (wr_idx >= int'(cur_len) || wr_idx >= ExpMax) begin
          errors++;
          $display("error at %0t ns: more external writes than words in the job", $time);
        end else begin
          check_addr(ext_req_addr_o, cur_dst + addr_t'(4 * wr_idx), "external write address");
          check_data(ext_req_wdata_o, exp_words[wr_idx], "external write data");
        end
        wr_idx++;
      end else begin
        check_addr(ext_req_addr_o, cur_src + addr_t'(4 * rd_idx), "external read address");
        rd_idx++;
      end
    end
    if (ext_rep_valid_i && ext_rep_err_i) err_seen = 1'b1;
  endtask

  // ----------------------------
  // external memory model
  // ----------------------------
  initial begin : ext_memory_model
    logic        we;
    addr_t       addr;
    data_t       wdata;
    int          delay;
    int          stall;
    int          idx;
    logic [15:0] lfsr_ext;
    ext_req_ready_i = 1'b1;
    ext_rep_valid_i = 1'b0;
    ext_rep_rdata_i = '0;
    ext_rep_err_i   = 1'b0;
    lfsr_ext        = 16'd94;
    forever begin
      @(posedge clk_i);
      if (reset_i) begin
        for (int i = 0; i < ExtWords; i++) ext_mem[i] = ext_init_word(i);
      end else begin
        if (ext_req_valid_o && ext_req_ready_i) begin
          we    = ext_req_we_o;
          addr  = ext_req_addr_o;
          wdata = ext_req_wdata_o;
          idx   = is_ext(addr) ? int'((addr - ExtBase) >> 2) : -1;
          // reply delay of 0 to 3 cycles
          take_bits(lfsr_ext, 2, delay);
          #1;
          if (we && idx >= 0) ext_mem[idx] = wdata;
          repeat (delay) @(posedge clk_i);
          if (delay > 0) #1;
          ext_rep_valid_i = 1'b1;
          ext_rep_rdata_i = (!we && idx >= 0) ? ext_mem[idx] : '0;
          ext_rep_err_i   = !we && addr == err_addr;
          @(posedge clk_i);
          #1;
          ext_rep_valid_i = 1'b0;
          ext_rep_err_i   = 1'b0;
        end else begin
          #1;
        end
        // request ready dropped at random, about one cycle in four
        take_bits(lfsr_ext, 2, stall);
        ext_req_ready_i = (stall != 0);
      end
    end
  end

  // ----------------------------
  // job driver
  // ----------------------------
  task automatic run_job(input addr_t src, input addr_t dst, input len_t len,
                         input status_e exp);
    int      cycles;
    int      vcycles;
    int      rnd;
    int      exp_count;
    logic    done;
    logic    pending;
    status_e got;
    cur_src   = src;
    cur_dst   = dst;
    cur_len   = len;
    rd_idx    = 0;
    wr_idx    = 0;
    ext_count = 0;
    err_seen  = 1'b0;
    got       = STATUS_OK;
    // expected words follow from the copy rule, word i of src to dst plus 4i
    for (int i = 0; i < int'(len) && i < ExpMax; i++) begin
      exp_words[i] = ref_read(src + addr_t'(4 * i));
    end
    job_valid_i = 1'b1;
    job_src_i   = src;
    job_dst_i   = dst;
    job_len_i   = len;
    cycles      = 0;
    done        = 1'b0;
    while (!done && cycles < AcceptTimeout) begin
      @(posedge clk_i);
      cycles++;
      watch_ext_bus();
      done = job_ready_o;
    end
    #1;
    job_valid_i = 1'b0;
    if (!done) begin
      timeouts++;
      $display("timeout: job from %h to %h was never accepted", src, dst);
      return;
    end
    cycles  = 0;
    vcycles = 0;
    done    = 1'b0;
    pending = 1'b0;
    while (!done && cycles < RspTimeout) begin
      @(posedge clk_i);
      cycles++;
      watch_ext_bus();
      // zero length job answers one cycle after acceptance
      if (len == '0 && cycles == 1) begin
        check_flag(rsp_valid_o, 1'b1, "rsp_valid_o after a zero length job");
      end
      if (pending) begin
        check_flag(rsp_valid_o, 1'b1, "rsp_valid_o under back-pressure");
        check_status(rsp_status_o, exp, "rsp_status_o under back-pressure");
      end
      if (rsp_valid_o) begin
        check_flag(job_ready_o, 1'b0, "job_ready_o while a response is pending");
        got = rsp_status_o;
        if (rsp_ready_i) begin
          done = 1'b1;
        end else begin
          pending = 1'b1;
          vcycles++;
        end
      end
      #1;
      // response always stalled for two cycles, then at random
      take_bits(lfsr_rsp, 1, rnd);
      rsp_ready_i = (vcycles >= 2) && (rnd == 1);
    end
    rsp_ready_i = 1'b0;
    if (!done) begin
      timeouts++;
      $display("timeout: no response for job from %h to %h", src, dst);
      return;
    end
    check_status(got, exp, "job status");
    if (exp == STATUS_BUS_ERR) begin
      check_flag(err_seen, 1'b1, "error reply seen");
    end else begin
      exp_count = (is_ext(src) ? int'(len) : 0) + (is_ext(dst) ? int'(len) : 0);
      check_data(data_t'(ext_count), data_t'(exp_count), "external request count");
    end
    if (exp == STATUS_OK) begin
      for (int i = 0; i < int'(len) && i < ExpMax; i++) begin
        ref_write(dst + addr_t'(4 * i), exp_words[i]);
      end
    end
  endtask

  // ----------------------------
  // main sequence
  // ----------------------------
  initial begin : main_sequence
    int n_jobs;
    int base;
    reset_i     = 1'b1;
    job_valid_i = 1'b0;
    job_src_i   = '0;
    job_dst_i   = '0;
    job_len_i   = '0;
    rsp_ready_i = 1'b0;
    errors      = 0;
    timeouts    = 0;
    lfsr_rsp    = 16'd94;
    $readmemh("dma_vectors.txt", vec);
    err_addr = vec[ErrAddrIdx];
    n_jobs   = int'(vec[JobCountIdx]);
    for (int i = 0; i < ExtWords; i++) ref_ext[i] = ext_init_word(i);

    repeat (16) @(posedge clk_i);
    check_flag(ext_req_valid_o, 1'b0, "ext_req_valid_o in reset");
    check_flag(rsp_valid_o, 1'b0, "rsp_valid_o in reset");
    #1;
    reset_i = 1'b0;
    @(posedge clk_i);
    check_flag(job_ready_o, 1'b0, "job_ready_o first cycle after reset");
    check_flag(ext_req_valid_o, 1'b0, "ext_req_valid_o after reset");
    check_flag(rsp_valid_o, 1'b0, "rsp_valid_o after reset");
    @(posedge clk_i);
    check_flag(job_ready_o, 1'b1, "job_ready_o while idle");
    #1;

    for (int j = 0; j < n_jobs && timeouts == 0; j++) begin
      base = JobBaseIdx + 4 * j;
      run_job(vec[base], vec[base + 1], len_t'(vec[base + 2][15:0]),
              status_e'(vec[base + 3][1:0]));
    end

    // final external contents against the reference
    for (int i = 0; i < ExtWords; i++) begin
      check_data(ext_mem[i], ref_ext[i], $sformatf("external word %0d", i));
    end

    $display("value errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
